// ==== hdl/clock_pkg.sv ====
// Shared types and constants of the digital clock; compile it first and import it where needed
package clock_pkg;

	// ------------------------------------------------------------------------
	// Control encodings
	// ------------------------------------------------------------------------

	// Running or setting the time
	typedef enum logic [1:0] {
		MODE_RUN   = 2'd0,
		MODE_SETUP = 2'd1
	} mode_e;

	// Field that the increment button steps in setup
	typedef enum logic [1:0] {
		FIELD_SEC  = 2'd0,
		FIELD_MIN  = 2'd1,
		FIELD_HOUR = 2'd2
	} field_e;

	// ------------------------------------------------------------------------
	// Time counts
	// ------------------------------------------------------------------------
	localparam int COUNT_W = 6;

	typedef logic [COUNT_W-1:0] count_t;

	// Last value before the wrap to zero
	localparam count_t SEC_MAX  = count_t'(59);
	localparam count_t HOUR_MAX = count_t'(23);

	// ------------------------------------------------------------------------
	// Display and buttons
	// ------------------------------------------------------------------------
	localparam int DIGIT_W    = 4;
	localparam int DIGIT_BASE = 10;
	localparam int SEG_W      = 7;

	// Segments a to g, a in the top bit, active high
	typedef logic [SEG_W-1:0] seg_t;

	localparam seg_t SEG_OFF = '0;

	localparam int NUM_DIGITS = 6;
	localparam int KEY_W      = 3;

endpackage

// ==== hdl/tick_gen.sv ====
// Clock-enable strobe generator; instantiate once per rate with DIV clk cycles between strobes
`timescale 1ns/1ps

module tick_gen #(
	parameter int unsigned DIV = 10
) (
	input  logic clk,
	input  logic rst_n,
	output logic o_tick
);

	localparam int unsigned CNT_W = (DIV > 1) ? $clog2(DIV) : 1;
	localparam logic [CNT_W-1:0] LAST = CNT_W'(DIV - 1);

	logic [CNT_W-1:0] cnt;

	// Strobe is registered on the wrap to zero
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt    <= '0;
			o_tick <= 1'b0;
		end else if (cnt == LAST) begin
			cnt    <= '0;
			o_tick <= 1'b1;
		end else begin
			cnt    <= cnt + 1'b1;
			o_tick <= 1'b0;
		end
	end

	// First strobe lands DIV cycles after reset release

endmodule

// ==== hdl/key_press.sv ====
// Button front end; turns the three active-low buttons into one-cycle press pulses on clk
`timescale 1ns/1ps

module key_press (
	input  logic clk,
	input  logic rst_n,
	input  logic i_sample,
	input  logic i_mode_key_n,
	input  logic i_field_key_n,
	input  logic i_inc_key_n,
	output logic o_mode_press,
	output logic o_field_press,
	output logic o_inc_press
);

	import clock_pkg::*;

	logic [KEY_W-1:0] key_n;
	logic [KEY_W-1:0] sync1_n;
	logic [KEY_W-1:0] sync2_n;
	logic [KEY_W-1:0] level_n;
	logic [KEY_W-1:0] prev_n;
	logic             sampled;
	logic [KEY_W-1:0] press;

	// Bit 0 mode, bit 1 field, bit 2 increment
	assign key_n = {i_inc_key_n, i_field_key_n, i_mode_key_n};

	// Two-flop synchroniser, released state out of reset
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sync1_n <= '1;
			sync2_n <= '1;
		end else begin
			sync1_n <= key_n;
			sync2_n <= sync1_n;
		end
	end

	// Level and previous level only move on the sample strobe
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			level_n <= '1;
			prev_n  <= '1;
			sampled <= 1'b0;
		end else begin
			sampled <= i_sample;
			if (i_sample) begin
				prev_n  <= level_n;
				level_n <= sync2_n;
			end
		end
	end

	// One cycle after a sample that went from high to low
	assign press = prev_n & ~level_n & {KEY_W{sampled}};

	assign o_mode_press  = press[0];
	assign o_field_press = press[1];
	assign o_inc_press   = press[2];

endmodule

// ==== hdl/clock_ctrl.sv ====
// Mode and field controller; maps the second tick and button presses onto counter step strobes
`timescale 1ns/1ps

module clock_ctrl (
	input  logic clk,
	input  logic rst_n,
	input  logic i_sec_tick,
	input  logic i_mode_press,
	input  logic i_field_press,
	input  logic i_inc_press,
	output logic o_sec_step,
	output logic o_min_step,
	output logic o_hour_step,
	output logic o_carry_en
);

	import clock_pkg::*;

	mode_e  mode;
	field_e field;

	// ------------------------------------------------------------------------
	// Mode and field state
	// ------------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mode <= MODE_RUN;
		end else if (i_mode_press) begin
			if (mode == MODE_RUN) begin
				mode <= MODE_SETUP;
			end else begin
				mode <= MODE_RUN;
			end
		end
	end

	// Setup always starts on the seconds
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			field <= FIELD_SEC;
		end else if (i_mode_press && (mode == MODE_RUN)) begin
			field <= FIELD_SEC;
		end else if (i_field_press && (mode == MODE_SETUP)) begin
			case (field)
				FIELD_SEC:  field <= FIELD_MIN;
				FIELD_MIN:  field <= FIELD_HOUR;
				default:    field <= FIELD_SEC;
			endcase
		end
	end

	// ------------------------------------------------------------------------
	// Step strobes, same cycle as tick or press
	// ------------------------------------------------------------------------
	always_comb begin
		o_sec_step  = 1'b0;
		o_min_step  = 1'b0;
		o_hour_step = 1'b0;
		o_carry_en  = 1'b0;
		case (mode)
			MODE_RUN: begin
				o_sec_step = i_sec_tick;
				o_carry_en = 1'b1;
			end
			MODE_SETUP: begin
				// Clock frozen, only the selected field steps
				case (field)
					FIELD_SEC:  o_sec_step  = i_inc_press;
					FIELD_MIN:  o_min_step  = i_inc_press;
					FIELD_HOUR: o_hour_step = i_inc_press;
					default:    o_sec_step  = 1'b0;
				endcase
			end
			default: o_carry_en = 1'b0;
		endcase
	end

endmodule

// ==== hdl/time_counter.sv ====
// Hours, minutes and seconds counters; stepped by the controller strobes with optional carry
`timescale 1ns/1ps

module time_counter (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              i_sec_step,
	input  logic              i_min_step,
	input  logic              i_hour_step,
	input  logic              i_carry_en,
	output clock_pkg::count_t o_sec,
	output clock_pkg::count_t o_min,
	output clock_pkg::count_t o_hour
);

	import clock_pkg::*;

	logic sec_wrap;
	logic min_inc;
	logic min_wrap;
	logic hour_inc;

	// Next value of a count that wraps to zero after last
	function automatic count_t step_count(input count_t cnt, input count_t last);
		return (cnt == last) ? '0 : cnt + 1'b1;
	endfunction

	// ------------------------------------------------------------------------
	// Carry chain
	// ------------------------------------------------------------------------
	assign sec_wrap = i_sec_step && (o_sec == SEC_MAX);
	assign min_inc  = i_min_step || (i_carry_en && sec_wrap);
	assign min_wrap = min_inc && (o_min == SEC_MAX);

	// Hours follow only a minutes wrap with carry enabled
	assign hour_inc = i_hour_step || (i_carry_en && min_wrap);

	// ------------------------------------------------------------------------
	// Count registers
	// ------------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_sec  <= '0;
			o_min  <= '0;
			o_hour <= '0;
		end else begin
			if (i_sec_step) begin
				o_sec <= step_count(o_sec, SEC_MAX);
			end
			if (min_inc) begin
				o_min <= step_count(o_min, SEC_MAX);
			end
			if (hour_inc) begin
				o_hour <= step_count(o_hour, HOUR_MAX);
			end
		end
	end

endmodule

// ==== hdl/seg_display.sv ====
// Six-digit multiplexed seven-segment driver; scans seconds, minutes and hours one slot per strobe
`timescale 1ns/1ps

module seg_display (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic                             i_scan,
	input  clock_pkg::count_t                i_sec,
	input  clock_pkg::count_t                i_min,
	input  clock_pkg::count_t                i_hour,
	output clock_pkg::seg_t                  o_seg,
	output logic [clock_pkg::NUM_DIGITS-1:0] o_digit_en_n
);

	import clock_pkg::*;

	localparam int SLOT_W = $clog2(NUM_DIGITS);
	localparam logic [SLOT_W-1:0] LAST_SLOT = SLOT_W'(NUM_DIGITS - 1);

	logic [SLOT_W-1:0]  slot;
	count_t             cur;
	logic [DIGIT_W-1:0] tens;
	logic [DIGIT_W-1:0] ones;
	logic [DIGIT_W-1:0] digit;

	// Standard active-high digit patterns, blank otherwise
	function automatic seg_t seg_decode(input logic [DIGIT_W-1:0] d);
		case (d)
			4'd0:    return 7'b111_1110;
			4'd1:    return 7'b011_0000;
			4'd2:    return 7'b110_1101;
			4'd3:    return 7'b111_1001;
			4'd4:    return 7'b011_0011;
			4'd5:    return 7'b101_1011;
			4'd6:    return 7'b101_1111;
			4'd7:    return 7'b111_0000;
			4'd8:    return 7'b111_1111;
			4'd9:    return 7'b111_0011;
			default: return SEG_OFF;
		endcase
	endfunction

	// ------------------------------------------------------------------------
	// Scan slot
	// ------------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			slot <= '0;
		end else if (i_scan) begin
			if (slot == LAST_SLOT) begin
				slot <= '0;
			end else begin
				slot <= slot + 1'b1;
			end
		end
	end

	// ------------------------------------------------------------------------
	// Digit select and decode
	// ------------------------------------------------------------------------

	// Two slots per count, ones digit in the even slot
	always_comb begin
		case (slot)
			0, 1:    cur = i_sec;
			2, 3:    cur = i_min;
			default: cur = i_hour;
		endcase
	end

	assign tens  = DIGIT_W'(cur / DIGIT_BASE);
	assign ones  = DIGIT_W'(cur % DIGIT_BASE);
	assign digit = slot[0] ? tens : ones;

	assign o_seg = seg_decode(digit);

	// Common enable low at the current slot only
	assign o_digit_en_n = ~(NUM_DIGITS'(1) << slot);

endmodule

// ==== hdl/digital_clock_top.sv ====
// Digital clock top level; set the three divider parameters for the clk rate in use
`timescale 1ns/1ps

module digital_clock_top #(
	parameter int unsigned SEC_DIV    = 50_000_000,
	parameter int unsigned SCAN_DIV   = 5_000,
	parameter int unsigned SAMPLE_DIV = 500_000
) (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic                             i_mode_key_n,
	input  logic                             i_field_key_n,
	input  logic                             i_inc_key_n,
	output clock_pkg::seg_t                  o_seg,
	output logic [clock_pkg::NUM_DIGITS-1:0] o_digit_en_n
);

	import clock_pkg::*;

	logic   sec_tick;
	logic   scan_tick;
	logic   sample_tick;
	logic   mode_press;
	logic   field_press;
	logic   inc_press;
	logic   sec_step;
	logic   min_step;
	logic   hour_step;
	logic   carry_en;
	count_t sec;
	count_t min;
	count_t hour;

	// ------------------------------------------------------------------------
	// Timebases
	// ------------------------------------------------------------------------
	tick_gen #(.DIV(SEC_DIV)) u_sec_tick (
		.clk    (clk),
		.rst_n  (rst_n),
		.o_tick (sec_tick)
	);

	tick_gen #(.DIV(SCAN_DIV)) u_scan_tick (
		.clk    (clk),
		.rst_n  (rst_n),
		.o_tick (scan_tick)
	);

	tick_gen #(.DIV(SAMPLE_DIV)) u_sample_tick (
		.clk    (clk),
		.rst_n  (rst_n),
		.o_tick (sample_tick)
	);

	// ------------------------------------------------------------------------
	// Buttons, control, counters and display
	// ------------------------------------------------------------------------
	key_press u_key_press (
		.clk           (clk),
		.rst_n         (rst_n),
		.i_sample      (sample_tick),
		.i_mode_key_n  (i_mode_key_n),
		.i_field_key_n (i_field_key_n),
		.i_inc_key_n   (i_inc_key_n),
		.o_mode_press  (mode_press),
		.o_field_press (field_press),
		.o_inc_press   (inc_press)
	);

	clock_ctrl u_clock_ctrl (
		.clk           (clk),
		.rst_n         (rst_n),
		.i_sec_tick    (sec_tick),
		.i_mode_press  (mode_press),
		.i_field_press (field_press),
		.i_inc_press   (inc_press),
		.o_sec_step    (sec_step),
		.o_min_step    (min_step),
		.o_hour_step   (hour_step),
		.o_carry_en    (carry_en)
	);

	time_counter u_time_counter (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_sec_step  (sec_step),
		.i_min_step  (min_step),
		.i_hour_step (hour_step),
		.i_carry_en  (carry_en),
		.o_sec       (sec),
		.o_min       (min),
		.o_hour      (hour)
	);

	seg_display u_seg_display (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_scan       (scan_tick),
		.i_sec        (sec),
		.i_min        (min),
		.i_hour       (hour),
		.o_seg        (o_seg),
		.o_digit_en_n (o_digit_en_n)
	);

endmodule

// ==== dv/tb_digital_clock.sv ====
// Self-checking testbench for the digital clock; compile with tb.f and run tb_digital_clock as top
`timescale 1ns/1ps

module tb_digital_clock;

	import clock_pkg::*;

	localparam int SEC_DIV    = 200;
	localparam int SCAN_DIV   = 4;
	localparam int SAMPLE_DIV = 10;
	// Worst case from button edge to the mode or count change
	localparam int PRESS_LAT  = 2 * SAMPLE_DIV + 4;
	localparam int SEC_LIM    = 60;
	localparam int HOUR_LIM   = 24;
	localparam int DAY_SECS   = HOUR_LIM * SEC_LIM * SEC_LIM;
	localparam int NUM_ROWS   = 9;

	logic                  clk;
	logic                  rst_n;
	logic                  i_mode_key_n;
	logic                  i_field_key_n;
	logic                  i_inc_key_n;
	seg_t                  o_seg;
	logic [NUM_DIGITS-1:0] o_digit_en_n;

	// Sequence letters are M mode, F field, I increment, H held increment,
	// S set the selected field to the row target and W wait the row run time
	string row_name [NUM_ROWS];
	string row_seq  [NUM_ROWS];
	int    row_run  [NUM_ROWS];
	int    row_hh   [NUM_ROWS];
	int    row_mm   [NUM_ROWS];
	int    row_ss   [NUM_ROWS];
	bit    row_win  [NUM_ROWS];
	bit    table_ready;
	seg_t  seg_pattern [DIGIT_BASE];

	// Reference state kept from the clock rules
	int mdl_h;
	int mdl_m;
	int mdl_s;
	bit in_setup;
	int field_sel;
	int base_tot;
	int run_lo;
	int run_hi;
	int inc_lo;
	int inc_hi;
	int cycles;
	int press_cycle;
	int cur_row;
	int errors;
	int checks;

	digital_clock_top #(
		.SEC_DIV    (SEC_DIV),
		.SCAN_DIV   (SCAN_DIV),
		.SAMPLE_DIV (SAMPLE_DIV)
	) u_digital_clock_top (
		.clk           (clk),
		.rst_n         (rst_n),
		.i_mode_key_n  (i_mode_key_n),
		.i_field_key_n (i_field_key_n),
		.i_inc_key_n   (i_inc_key_n),
		.o_seg         (o_seg),
		.o_digit_en_n  (o_digit_en_n)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Edges since reset release
	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cycles <= 0;
		end else begin
			cycles <= cycles + 1;
		end
	end

	task automatic set_row(input int idx, input string name, input string seq, input int run,
			input int hh, input int mm, input int ss, input bit win);
		row_name[idx] = name;
		row_seq[idx]  = seq;
		row_run[idx]  = run;
		row_hh[idx]   = hh;
		row_mm[idx]   = mm;
		row_ss[idx]   = ss;
		row_win[idx]  = win;
	endtask

	task automatic load_table();
		seg_pattern[0] = 7'b111_1110;
		seg_pattern[1] = 7'b011_0000;
		seg_pattern[2] = 7'b110_1101;
		seg_pattern[3] = 7'b111_1001;
		seg_pattern[4] = 7'b011_0011;
		seg_pattern[5] = 7'b101_1011;
		seg_pattern[6] = 7'b101_1111;
		seg_pattern[7] = 7'b111_0000;
		seg_pattern[8] = 7'b111_1111;
		seg_pattern[9] = 7'b111_0011;
		set_row(0, "reset_scan",  "",      0, 0,  0,  0,  1'b0);
		set_row(1, "run_freeze",  "WM",    4, 0,  0,  0,  1'b1);
		set_row(2, "set_time",    "SFSFS", 0, 23, 59, 58, 1'b0);
		set_row(3, "frozen_hold", "W",     3, 23, 59, 58, 1'b0);
		set_row(4, "sec_wrap",    "FII",   0, 23, 59, 0,  1'b0);
		set_row(5, "hour_wrap",   "FFI",   0, 0,  59, 0,  1'b0);
		set_row(6, "held_inc",    "H",     0, 1,  59, 0,  1'b0);
		set_row(7, "restore",     "SFS",   0, 23, 59, 58, 1'b0);
		set_row(8, "rollover",    "MWM",   3, 0,  0,  0,  1'b1);
	endtask

	// Run time, six sample periods per press, one scan per row, plus half again
	function automatic int watchdog_cycles();
		int total;
		int presses;
		total = 8 * SEC_DIV;
		for (int r = 0; r < NUM_ROWS; r++) begin
			presses = 0;
			for (int k = 0; k < row_seq[r].len(); k++) begin
				case (row_seq[r].getc(k))
					"S":     presses += SEC_LIM + 2 * HOUR_LIM;
					"H":     presses += 2;
					"W":     presses += 0;
					default: presses += 1;
				endcase
			end
			total += row_run[r] * SEC_DIV + presses * 6 * SAMPLE_DIV;
			total += (NUM_DIGITS + 1) * SCAN_DIV;
		end
		return total + total / 2;
	endfunction

	task automatic check_value(input string name, input string what,
			input int exp, input int act);
		checks++;
		if (exp != act) begin
			$display("Fail %s %s: expected %0d, actual %0d", name, what, exp, act);
			errors++;
		end
	endtask

	// Button held low for three samples plus extra, then released for three
	task automatic press_key(input int which, input int extra_hold);
		@(posedge clk);
		press_cycle = cycles;
		case (which)
			0:       i_mode_key_n  <= 1'b0;
			1:       i_field_key_n <= 1'b0;
			default: i_inc_key_n   <= 1'b0;
		endcase
		repeat (3 * SAMPLE_DIV + extra_hold) @(posedge clk);
		i_mode_key_n  <= 1'b1;
		i_field_key_n <= 1'b1;
		i_inc_key_n   <= 1'b1;
		repeat (3 * SAMPLE_DIV) @(posedge clk);
	endtask

	task automatic step_model();
		if (in_setup) begin
			case (field_sel)
				0:       mdl_s = (mdl_s + 1) % SEC_LIM;
				1:       mdl_m = (mdl_m + 1) % SEC_LIM;
				default: mdl_h = (mdl_h + 1) % HOUR_LIM;
			endcase
		end
	endtask

	task automatic apply_step(input byte c);
		int target;
		int cur;
		int lim;
		int n;
		case (c)
			"M": begin
				press_key(0, 0);
				if (in_setup) begin
					in_setup = 1'b0;
					base_tot = mdl_h * 3600 + mdl_m * SEC_LIM + mdl_s;
					run_lo   = press_cycle / SEC_DIV;
					run_hi   = (press_cycle + PRESS_LAT) / SEC_DIV;
				end else begin
					in_setup  = 1'b1;
					field_sel = 0;
					inc_lo    = press_cycle / SEC_DIV - run_hi;
					inc_hi    = (press_cycle + PRESS_LAT) / SEC_DIV - run_lo;
				end
			end
			"F": begin
				press_key(1, 0);
				if (in_setup) begin
					field_sel = (field_sel + 1) % 3;
				end
			end
			"I": begin
				press_key(2, 0);
				step_model();
			end
			"H": begin
				press_key(2, int'($urandom % (4 * SAMPLE_DIV)));
				step_model();
			end
			"S": begin
				target = (field_sel == 0) ? row_ss[cur_row] :
					(field_sel == 1) ? row_mm[cur_row] : row_hh[cur_row];
				cur = (field_sel == 0) ? mdl_s : (field_sel == 1) ? mdl_m : mdl_h;
				lim = (field_sel == 2) ? HOUR_LIM : SEC_LIM;
				n   = (target - cur + lim) % lim;
				// Hours may take a few extra full turns
				if (field_sel == 2) begin
					n = n + lim * int'($urandom % 3);
				end
				repeat (n) begin
					press_key(2, 0);
					step_model();
				end
			end
			default: repeat (row_run[cur_row] * SEC_DIV) @(posedge clk);
		endcase
	endtask

	// Reads one scan and a bit on the falling edge
	task automatic read_display(output int hh, output int mm, output int ss);
		int digits [NUM_DIGITS];
		bit seen [NUM_DIGITS];
		int slot;
		int prev_slot;
		int d;
		prev_slot = -1;
		for (int i = 0; i < NUM_DIGITS; i++) begin
			digits[i] = 0;
			seen[i]   = 1'b0;
		end
		repeat ((NUM_DIGITS + 1) * SCAN_DIV) begin
			@(negedge clk);
			if ($countones(~o_digit_en_n) != 1) begin
				$display("%s: digit enables are not one-hot", row_name[cur_row]);
				errors++;
			end else begin
				for (int i = 0; i < NUM_DIGITS; i++) begin
					if (!o_digit_en_n[i]) begin
						slot = i;
					end
				end
				if (prev_slot >= 0 && slot != prev_slot &&
						slot != (prev_slot + 1) % NUM_DIGITS) begin
					$display("%s: scan jumped from slot %0d to %0d",
						row_name[cur_row], prev_slot, slot);
					errors++;
				end
				d = -1;
				for (int i = 0; i < DIGIT_BASE; i++) begin
					if (seg_pattern[i] == o_seg) begin
						d = i;
					end
				end
				if (d < 0) begin
					$display("%s: unknown segment pattern %b", row_name[cur_row], o_seg);
					errors++;
				end
				digits[slot] = d;
				seen[slot]   = 1'b1;
				prev_slot    = slot;
			end
		end
		for (int i = 0; i < NUM_DIGITS; i++) begin
			if (!seen[i]) begin
				$display("%s: slot %0d was never enabled", row_name[cur_row], i);
				errors++;
			end
		end
		hh = digits[5] * 10 + digits[4];
		mm = digits[3] * 10 + digits[2];
		ss = digits[1] * 10 + digits[0];
	endtask

	// ------------------------------------------------------------------------
	// Watchdog
	// ------------------------------------------------------------------------
	initial begin : watchdog
		int limit;
		wait (table_ready);
		limit = watchdog_cycles();
		repeat (limit) @(posedge clk);
		$display("Timeout: the run did not finish within %0d cycles", limit);
		$display("** FAIL **");
		$finish;
	end

	// ------------------------------------------------------------------------
	// Main sequence
	// ------------------------------------------------------------------------
	initial begin
		int hh;
		int mm;
		int ss;
		int elapsed;
		void'($urandom(32'hcb9b));
		rst_n         = 1'b0;
		i_mode_key_n  = 1'b1;
		i_field_key_n = 1'b1;
		i_inc_key_n   = 1'b1;
		errors        = 0;
		checks        = 0;
		cur_row       = 0;
		mdl_h         = 0;
		mdl_m         = 0;
		mdl_s         = 0;
		in_setup      = 1'b0;
		field_sel     = 0;
		base_tot      = 0;
		run_lo        = 0;
		run_hi        = 0;
		load_table();
		table_ready = 1'b1;
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check_value("reset", "digit enable", int'({{(NUM_DIGITS - 1){1'b1}}, 1'b0}),
			int'(o_digit_en_n));
		for (int r = 0; r < NUM_ROWS; r++) begin
			cur_row = r;
			for (int k = 0; k < row_seq[r].len(); k++) begin
				apply_step(row_seq[r].getc(k));
			end
			read_display(hh, mm, ss);
			check_value(row_name[r], "hours", row_hh[r], hh);
			check_value(row_name[r], "minutes", row_mm[r], mm);
			if (row_win[r]) begin
				// Seconds counted while running fall inside the latency window
				elapsed = (hh * 3600 + mm * SEC_LIM + ss - base_tot + DAY_SECS) % DAY_SECS;
				checks++;
				if (elapsed < inc_lo || elapsed > inc_hi) begin
					$display("Fail %s seconds run: expected %0d to %0d, actual %0d",
						row_name[r], inc_lo, inc_hi, elapsed);
					errors++;
				end
				mdl_h = hh;
				mdl_m = mm;
				mdl_s = ss;
			end else begin
				check_value(row_name[r], "seconds", row_ss[r], ss);
			end
		end
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

// ==== tb.f ====
hdl/clock_pkg.sv
hdl/tick_gen.sv
hdl/key_press.sv
hdl/clock_ctrl.sv
hdl/time_counter.sv
hdl/seg_display.sv
hdl/digital_clock_top.sv
dv/tb_digital_clock.sv

// ==== Makefile ====
# Verilator build and run of the digital clock testbench

VERILATOR ?= verilator
TOP       ?= tb_digital_clock
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

FAIL_MSG  := ** FAIL **
PASS_MSG  := ** PASS **
SOURCES   := $(shell grep -v '^+' $(FILELIST))
SIM_BIN   := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   list these targets"

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

test: $(SIM_BIN)
	-$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	elif ! grep -qF '$(PASS_MSG)' $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	else \
		echo "Simulation passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
